/* verilog/approx_mult_cfg.svh */
`ifndef APPROX_MULT_CFG_SVH
`define APPROX_MULT_CFG_SVH

// operand and result widths
`define AM_OPERAND_W    16
`define AM_TRUNC_W      8
`define AM_PRODUCT_W    16
`define AM_RESULT_W     32

// batch and memory sizes
`define AM_PAIRS        8
`define AM_OP_DEPTH     16
`define AM_OP_ADDR_W    4
`define AM_RES_ADDR_W   3

// shift limits and counter widths
`define AM_MAX_SHIFT    8
`define AM_SHIFT_CNT_W  4
`define AM_DSHIFT_CNT_W 5

`endif

/* verilog/approx_mult_pkg.sv */
`include "approx_mult_cfg.svh"

package approx_mult_pkg;

    typedef logic [`AM_OPERAND_W-1:0]    operand_t;
    typedef logic [`AM_TRUNC_W-1:0]      trunc_t;
    typedef logic [`AM_PRODUCT_W-1:0]    product_t;
    typedef logic [`AM_RESULT_W-1:0]     result_t;
    typedef logic [`AM_OP_ADDR_W-1:0]    op_addr_t;
    typedef logic [`AM_RES_ADDR_W-1:0]   res_addr_t;
    typedef logic [`AM_SHIFT_CNT_W-1:0]  shift_cnt_t;
    typedef logic [`AM_DSHIFT_CNT_W-1:0] dshift_cnt_t;

    // one state per step of the per-pair sequence
    typedef enum logic [2:0] {
        IDLE,
        FETCH_A,
        LOAD_A,
        LOAD_B,
        NORMALIZE,
        PRODUCT,
        DENORM,
        WRITE
    } ctrl_state_e;

    // strobes from controller to datapath
    typedef struct packed {
        logic op_addr_clear;
        logic op_addr_inc;
        logic load_a;
        logic load_b;
        logic norm_en;
        logic load_product;
        logic denorm_en;
        logic res_write;
        logic res_addr_clear;
        logic res_addr_inc;
    } dp_ctrl_t;

    // flags back to the controller
    typedef struct packed {
        logic norm_done;
        logic denorm_done;
        logic last_pair;
    } dp_status_t;

endpackage

/* verilog/operand_normalizer.sv */
`timescale 1ns/1ps
`include "approx_mult_cfg.svh"

module operand_normalizer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        load,
    input  logic                        shift_en,
    input  approx_mult_pkg::operand_t   data,
    output approx_mult_pkg::trunc_t     trunc,
    output approx_mult_pkg::shift_cnt_t count,
    output logic                        done
);
    import approx_mult_pkg::*;

    operand_t   shreg;
    shift_cnt_t cnt;

    // leading one reached or limit hit
    assign done = shreg[`AM_OPERAND_W-1] || (cnt == shift_cnt_t'(`AM_MAX_SHIFT));

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= data;
        end else if (shift_en && !done) begin
            shreg <= shreg << 1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= '0;
        end else if (shift_en && !done) begin
            cnt <= cnt + shift_cnt_t'(1);
        end
    end

    assign trunc = shreg[`AM_OPERAND_W-1 -: `AM_TRUNC_W];
    assign count = cnt;

endmodule

/* verilog/operand_ram.sv */
`timescale 1ns/1ps
`include "approx_mult_cfg.svh"

module operand_ram (
    input  logic                      clk,
    input  logic                      wr_en,
    input  approx_mult_pkg::op_addr_t wr_addr,
    input  approx_mult_pkg::operand_t wr_data,
    input  approx_mult_pkg::op_addr_t rd_addr,
    output approx_mult_pkg::operand_t rd_data
);
    import approx_mult_pkg::*;

    // pair k at 2k and 2k+1
    operand_t mem [`AM_OP_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/result_ram.sv */
`timescale 1ns/1ps
`include "approx_mult_cfg.svh"

module result_ram (
    input  logic                       clk,
    input  logic                       wr_en,
    input  approx_mult_pkg::res_addr_t wr_addr,
    input  approx_mult_pkg::result_t   wr_data,
    input  approx_mult_pkg::res_addr_t rd_addr,
    output approx_mult_pkg::result_t   rd_data
);
    import approx_mult_pkg::*;

    // one word per pair
    result_t mem [`AM_PAIRS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/approx_mult_datapath.sv */
`timescale 1ns/1ps
`include "approx_mult_cfg.svh"

module approx_mult_datapath (
    input  logic                        clk,
    input  logic                        arst_n,
    input  approx_mult_pkg::dp_ctrl_t   ctrl,
    output approx_mult_pkg::dp_status_t status,
    output approx_mult_pkg::op_addr_t   op_rd_addr,
    input  approx_mult_pkg::operand_t   op_rd_data,
    output logic                        res_wr_en,
    output approx_mult_pkg::res_addr_t  res_wr_addr,
    output approx_mult_pkg::result_t    res_wr_data
);
    import approx_mult_pkg::*;

    op_addr_t    op_addr;
    res_addr_t   res_addr;
    trunc_t      trunc_a;
    trunc_t      trunc_b;
    shift_cnt_t  count_a;
    shift_cnt_t  count_b;
    logic        done_a;
    logic        done_b;
    product_t    product;
    result_t     out_reg;
    dshift_cnt_t dshift_cnt;

    // operand address, two steps per pair
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_addr <= '0;
        end else if (ctrl.op_addr_clear) begin
            op_addr <= '0;
        end else if (ctrl.op_addr_inc) begin
            op_addr <= op_addr + op_addr_t'(1);
        end
    end

    operand_normalizer u_norm_a (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (ctrl.load_a),
        .shift_en (ctrl.norm_en),
        .data     (op_rd_data),
        .trunc    (trunc_a),
        .count    (count_a),
        .done     (done_a)
    );

    operand_normalizer u_norm_b (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (ctrl.load_b),
        .shift_en (ctrl.norm_en),
        .data     (op_rd_data),
        .trunc    (trunc_b),
        .count    (count_b),
        .done     (done_b)
    );

    // truncated 8x8 multiply
    assign product = trunc_a * trunc_b;

    // product goes to the upper half, then shifts back by sa+sb
    always_ff @(posedge clk) begin
        if (ctrl.load_product) begin
            out_reg <= {product, {(`AM_RESULT_W - `AM_PRODUCT_W){1'b0}}};
        end else if (ctrl.denorm_en && (dshift_cnt != '0)) begin
            out_reg <= out_reg >> 1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dshift_cnt <= '0;
        end else if (ctrl.load_product) begin
            dshift_cnt <= dshift_cnt_t'(count_a) + dshift_cnt_t'(count_b);
        end else if (ctrl.denorm_en && (dshift_cnt != '0)) begin
            dshift_cnt <= dshift_cnt - dshift_cnt_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_addr <= '0;
        end else if (ctrl.res_addr_clear) begin
            res_addr <= '0;
        end else if (ctrl.res_addr_inc) begin
            res_addr <= res_addr + res_addr_t'(1);
        end
    end

    assign op_rd_addr  = op_addr;
    assign res_wr_en   = ctrl.res_write;
    assign res_wr_addr = res_addr;
    assign res_wr_data = out_reg;

    assign status.norm_done   = done_a & done_b;
    assign status.denorm_done = (dshift_cnt == '0);
    assign status.last_pair   = (res_addr == res_addr_t'(`AM_PAIRS - 1));

endmodule

/* verilog/approx_mult_controller.sv */
`timescale 1ns/1ps

module approx_mult_controller (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  approx_mult_pkg::dp_status_t status,
    output approx_mult_pkg::dp_ctrl_t   ctrl,
    output logic                        busy,
    output logic                        done
);
    import approx_mult_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        accept;
    logic        finish;

    assign accept = (state == IDLE) && start;
    assign finish = (state == WRITE) && status.last_pair;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // done lands one cycle after the last write
            done  <= finish;
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        ctrl      = '0;
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    ctrl.op_addr_clear  = 1'b1;
                    ctrl.res_addr_clear = 1'b1;
                    state_nxt           = FETCH_A;
                end
            end
            FETCH_A: begin
                // present address of a, step to b
                ctrl.op_addr_inc = 1'b1;
                state_nxt        = LOAD_A;
            end
            LOAD_A: begin
                ctrl.load_a      = 1'b1;
                ctrl.op_addr_inc = 1'b1;
                state_nxt        = LOAD_B;
            end
            LOAD_B: begin
                ctrl.load_b = 1'b1;
                state_nxt   = NORMALIZE;
            end
            NORMALIZE: begin
                ctrl.norm_en = 1'b1;
                if (status.norm_done) begin
                    state_nxt = PRODUCT;
                end
            end
            PRODUCT: begin
                ctrl.load_product = 1'b1;
                state_nxt         = DENORM;
            end
            DENORM: begin
                ctrl.denorm_en = 1'b1;
                if (status.denorm_done) begin
                    state_nxt = WRITE;
                end
            end
            WRITE: begin
                ctrl.res_write    = 1'b1;
                ctrl.res_addr_inc = 1'b1;
                if (status.last_pair) begin
                    state_nxt = IDLE;
                end else begin
                    state_nxt = FETCH_A;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

/* verilog/approx_mult_top.sv */
`timescale 1ns/1ps

module approx_mult_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    output logic                       busy,
    output logic                       done,
    input  logic                       op_wr_en,
    input  approx_mult_pkg::op_addr_t  op_wr_addr,
    input  approx_mult_pkg::operand_t  op_wr_data,
    input  approx_mult_pkg::res_addr_t res_rd_addr,
    output approx_mult_pkg::result_t   res_rd_data
);
    import approx_mult_pkg::*;

    dp_ctrl_t   ctrl;
    dp_status_t status;

    op_addr_t   op_rd_addr;
    operand_t   op_rd_data;

    logic       res_wr_en;
    res_addr_t  res_wr_addr;
    result_t    res_wr_data;

    approx_mult_controller u_ctrl (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .status (status),
        .ctrl   (ctrl),
        .busy   (busy),
        .done   (done)
    );

    approx_mult_datapath u_dp (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl),
        .status      (status),
        .op_rd_addr  (op_rd_addr),
        .op_rd_data  (op_rd_data),
        .res_wr_en   (res_wr_en),
        .res_wr_addr (res_wr_addr),
        .res_wr_data (res_wr_data)
    );

    // operands loaded from outside while idle
    operand_ram u_op_ram (
        .clk     (clk),
        .wr_en   (op_wr_en),
        .wr_addr (op_wr_addr),
        .wr_data (op_wr_data),
        .rd_addr (op_rd_addr),
        .rd_data (op_rd_data)
    );

    result_ram u_res_ram (
        .clk     (clk),
        .wr_en   (res_wr_en),
        .wr_addr (res_wr_addr),
        .wr_data (res_wr_data),
        .rd_addr (res_rd_addr),
        .rd_data (res_rd_data)
    );

endmodule

/* testbench/tb_approx_mult.sv */
`timescale 1ns/1ps
`include "approx_mult_cfg.svh"

module tb_approx_mult;
    import approx_mult_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int PAIR_CYCLES = 40;
    localparam int BATCHES     = 6;
    localparam int DONE_LIMIT  = `AM_PAIRS * PAIR_CYCLES;
    localparam int WATCHDOG_NS = BATCHES * DONE_LIMIT * CLK_PERIOD + 10000;

    logic        clk;
    logic        arst_n;
    logic        start;
    logic        busy;
    logic        done;
    logic        op_wr_en;
    op_addr_t    op_wr_addr;
    operand_t    op_wr_data;
    res_addr_t   res_rd_addr;
    result_t     res_rd_data;

    operand_t    ops [`AM_OP_DEPTH];
    result_t     got [`AM_PAIRS];
    result_t     first_read [`AM_PAIRS];
    int          errors = 0;
    int          proto_errors = 0;
    int          checks = 0;
    int          done_total;
    int          dones_before;
    logic        arst_q;

    approx_mult_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .op_wr_en    (op_wr_en),
        .op_wr_addr  (op_wr_addr),
        .op_wr_data  (op_wr_data),
        .res_rd_addr (res_rd_addr),
        .res_rd_data (res_rd_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // low in reset and in the first cycle after release
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arst_q <= 1'b0;
        end else begin
            arst_q <= 1'b1;
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_total <= 0;
        end else if (done) begin
            done_total <= done_total + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) (!arst_n || !arst_q) |-> (!busy && !done))
        else begin
            $display("busy or done high during or right after reset at %0t", $time);
            proto_errors++;
        end
    a_done_needs_busy: assert property (@(posedge clk) disable iff (!arst_n) done |-> $past(busy))
        else begin
            $display("done pulsed without a running batch at %0t", $time);
            proto_errors++;
        end
    a_done_single: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            $display("done stayed high for more than one cycle at %0t", $time);
            proto_errors++;
        end
    a_busy_drops_with_done: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> !busy)
        else begin
            $display("busy still high while done pulsed at %0t", $time);
            proto_errors++;
        end
    a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n) $fell(busy) |-> done)
        else begin
            $display("busy fell without a done pulse at %0t", $time);
            proto_errors++;
        end
    a_start_accept: assert property (@(posedge clk) disable iff (!arst_n)
        (start && !busy) |=> busy)
        else begin
            $display("busy did not rise after an accepted start at %0t", $time);
            proto_errors++;
        end

    // leading zeros capped at the normalization limit
    function automatic int lead_shift(operand_t x);
        int lz;
        lz = 0;
        while (lz < `AM_OPERAND_W && !x[`AM_OPERAND_W - 1 - lz]) begin
            lz++;
        end
        if (lz > `AM_MAX_SHIFT) begin
            lz = `AM_MAX_SHIFT;
        end
        return lz;
    endfunction

    function automatic result_t model_result(operand_t a, operand_t b);
        int       sa;
        int       sb;
        operand_t na;
        operand_t nb;
        product_t p;
        sa = lead_shift(a);
        sb = lead_shift(b);
        na = a << sa;
        nb = b << sb;
        p  = product_t'(na[`AM_OPERAND_W-1 -: `AM_TRUNC_W]) *
             product_t'(nb[`AM_OPERAND_W-1 -: `AM_TRUNC_W]);
        return result_t'(p) << ((`AM_RESULT_W - `AM_PRODUCT_W) - sa - sb);
    endfunction

    task automatic check_value(input string name, input result_t exp, input result_t act);
        checks++;
        assert (act == exp) else begin
            $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic write_operands();
        for (int i = 0; i < `AM_OP_DEPTH; i++) begin
            @(posedge clk);
            op_wr_en   <= 1'b1;
            op_wr_addr <= op_addr_t'(i);
            op_wr_data <= ops[i];
        end
        @(posedge clk);
        op_wr_en <= 1'b0;
    endtask

    // poke sends a second start while the batch is running
    task automatic run_batch(input string name, input bit poke);
        int cycles;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (poke) begin
            repeat (20) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: batch %s never signalled done", name);
            errors++;
        end
    endtask

    task automatic read_results();
        for (int i = 0; i < `AM_PAIRS; i++) begin
            @(posedge clk);
            res_rd_addr <= res_addr_t'(i);
            @(posedge clk);
            @(negedge clk);
            got[i] = res_rd_data;
        end
    endtask

    task automatic check_results(input string name);
        for (int i = 0; i < `AM_PAIRS; i++) begin
            check_value($sformatf("%s[%0d]", name, i),
                        model_result(ops[2*i], ops[2*i+1]), got[i]);
            if (ops[2*i] == '0 || ops[2*i+1] == '0) begin
                check_value($sformatf("%s_zero[%0d]", name, i), '0, got[i]);
            end
        end
    endtask

    task automatic check_done_count(input string name, input int expected);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value($sformatf("%s_done_count", name), result_t'(expected),
                    result_t'(done_total - dones_before));
    endtask

    task automatic fill_random();
        for (int i = 0; i < `AM_OP_DEPTH; i++) begin
            ops[i] = operand_t'($urandom);
        end
    endtask

    initial begin
        void'($urandom(58262));
        arst_n      = 1'b0;
        start       = 1'b0;
        op_wr_en    = 1'b0;
        op_wr_addr  = '0;
        op_wr_data  = '0;
        res_rd_addr = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge clk);

        // small operands are exact
        for (int i = 0; i < `AM_OP_DEPTH; i++) begin
            ops[i] = operand_t'($urandom_range(255, 0));
        end
        write_operands();
        dones_before = done_total;
        run_batch("exact_small", 1'b0);
        check_done_count("exact_small", 1);
        read_results();
        check_results("exact_small");
        for (int i = 0; i < `AM_PAIRS; i++) begin
            check_value($sformatf("exact_small_product[%0d]", i),
                        result_t'(ops[2*i]) * result_t'(ops[2*i+1]), got[i]);
        end

        ops = '{16'h0000, 16'h1234, 16'hFFFF, 16'hFFFF, 16'h8000, 16'h8000,
                16'h0001, 16'h8000, 16'hFFFF, 16'h0000, 16'h0100, 16'h0080,
                16'h0040, 16'h2000, 16'h0000, 16'h0000};
        write_operands();
        dones_before = done_total;
        run_batch("extremes", 1'b0);
        check_done_count("extremes", 1);
        read_results();
        check_results("extremes");

        // stray start while busy must leave the batch intact
        fill_random();
        write_operands();
        dones_before = done_total;
        run_batch("random_a", 1'b1);
        check_done_count("random_a", 1);
        read_results();
        check_results("random_a");

        // read twice with idle cycles in between
        fill_random();
        write_operands();
        dones_before = done_total;
        run_batch("random_b", 1'b0);
        check_done_count("random_b", 1);
        read_results();
        first_read = got;
        repeat (25) @(posedge clk);
        read_results();
        check_results("random_b");
        for (int i = 0; i < `AM_PAIRS; i++) begin
            check_value($sformatf("persist[%0d]", i), first_read[i], got[i]);
        end

        // a start right after done
        fill_random();
        write_operands();
        dones_before = done_total;
        run_batch("random_c", 1'b0);
        run_batch("random_chain", 1'b0);
        check_done_count("random_chain", 2);
        read_results();
        check_results("random_chain");

        repeat (4) @(posedge clk);
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/approx_mult_pkg.sv
verilog/operand_normalizer.sv
verilog/operand_ram.sv
verilog/result_ram.sv
verilog/approx_mult_datapath.sv
verilog/approx_mult_controller.sv
verilog/approx_mult_top.sv
testbench/tb_approx_mult.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_approx_mult \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
